// File: design/mem_route_pkg.sv
package mem_route_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = 4;
    localparam int TRACK_DEPTH    = 8;
    localparam int SB_DEPTH       = 4;
    localparam int MEM_CREDITS    = 4;
    localparam int SEG_CLEAR_BITS = 3;

    // Derived sizes
    localparam int TRK_PTR_W = $clog2(TRACK_DEPTH);
    localparam int SB_PTR_W  = $clog2(SB_DEPTH);
    localparam int CREDIT_W  = $clog2(MEM_CREDITS + 1);

    localparam logic [CREDIT_W-1:0] CREDIT_INIT  = CREDIT_W'(MEM_CREDITS);
    localparam logic [SB_PTR_W:0]   SB_COUNT_MAX = (SB_PTR_W + 1)'(SB_DEPTH);

    // Simple address mapping forces the top segment bits to zero
    localparam logic [ADDR_W-1:0] SEG_MASK = {ADDR_W{1'b1}} >> SEG_CLEAR_BITS;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic {
        PATH_UNCACHED = 1'b0,
        PATH_CACHED   = 1'b1
    } mem_path_e;

    typedef struct packed {
        logic              valid;
        mem_op_e           op;
        logic              cacheable;
        logic [1:0]        size;
        logic [STRB_W-1:0] wstrb;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        mem_op_e           op;
        logic [STRB_W-1:0] wstrb;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // On the CPU side valid is data_ok
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: design/route_tracker.sv
module route_tracker (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  mem_route_pkg::cpu_req_t cpu_req,
    input  logic                    cached_ready,
    input  logic                    uncached_ready,
    input  mem_route_pkg::mem_rsp_t cached_done,
    input  mem_route_pkg::mem_rsp_t uncached_done,
    output logic                    addr_ok,
    output logic                    cached_take,
    output logic                    uncached_take,
    output mem_route_pkg::mem_rsp_t cpu_rsp
);

    // Pointers carry one extra wrap bit
    logic [mem_route_pkg::TRK_PTR_W:0]     wr_ptr;
    logic [mem_route_pkg::TRK_PTR_W:0]     rd_ptr;
    logic [mem_route_pkg::TRK_PTR_W-1:0]   wr_idx;
    logic [mem_route_pkg::TRK_PTR_W-1:0]   rd_idx;
    mem_route_pkg::mem_path_e              path_ring [mem_route_pkg::TRACK_DEPTH];
    logic [mem_route_pkg::TRACK_DEPTH-1:0] write_ring;

    mem_route_pkg::mem_path_e req_path;
    mem_route_pkg::mem_path_e head_path;
    mem_route_pkg::mem_rsp_t  head_rsp;
    logic                     empty;
    logic                     full;
    logic                     stall;
    logic                     path_ready;
    logic                     accept;
    logic                     retire;

    ////////////////////////////////////////////////////////////////////////////
    // Accept side
    ////////////////////////////////////////////////////////////////////////////

    assign wr_idx = wr_ptr[mem_route_pkg::TRK_PTR_W-1:0];
    assign rd_idx = rd_ptr[mem_route_pkg::TRK_PTR_W-1:0];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_idx == rd_idx)
                && (wr_ptr[mem_route_pkg::TRK_PTR_W] != rd_ptr[mem_route_pkg::TRK_PTR_W]);

    assign req_path  = cpu_req.cacheable ? mem_route_pkg::PATH_CACHED
                                         : mem_route_pkg::PATH_UNCACHED;
    assign head_path = path_ring[rd_idx];

    // All open entries share one path, so the head stands for them all
    assign stall      = full || (!empty && (head_path != req_path));
    assign path_ready = (req_path == mem_route_pkg::PATH_CACHED) ? cached_ready
                                                                 : uncached_ready;

    assign addr_ok       = !stall && path_ready;
    assign accept        = cpu_req.valid && addr_ok;
    assign cached_take   = accept && (req_path == mem_route_pkg::PATH_CACHED);
    assign uncached_take = accept && (req_path == mem_route_pkg::PATH_UNCACHED);

    ////////////////////////////////////////////////////////////////////////////
    // Response side
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        head_rsp = (head_path == mem_route_pkg::PATH_CACHED) ? cached_done : uncached_done;
        cpu_rsp.valid = !empty && head_rsp.valid;
        // Stores answer with zero data
        cpu_rsp.rdata = write_ring[rd_idx] ? '0 : head_rsp.rdata;
    end

    assign retire = cpu_rsp.valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            path_ring[wr_idx]  <= req_path;
            write_ring[wr_idx] <= (cpu_req.op == mem_route_pkg::OP_WRITE);
        end
    end

endmodule

// File: design/store_buffer.sv
module store_buffer (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    take,
    input  mem_route_pkg::cpu_req_t cpu_req,
    input  logic                    issue_ready,
    input  mem_route_pkg::mem_rsp_t mem_rsp,
    output logic                    ready,
    output mem_route_pkg::mem_rsp_t done,
    output mem_route_pkg::mem_req_t issue_req
);

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        DRAIN
    } sb_state_e;

    sb_state_e                          state;
    sb_state_e                          state_next;
    mem_route_pkg::mem_req_t            queue [mem_route_pkg::SB_DEPTH];
    mem_route_pkg::mem_req_t            entry;
    mem_route_pkg::mem_req_t            rd_q;
    logic [mem_route_pkg::SB_PTR_W-1:0] head;
    logic [mem_route_pkg::SB_PTR_W-1:0] tail;
    logic [mem_route_pkg::SB_PTR_W:0]   count;
    logic [mem_route_pkg::SB_PTR_W:0]   count_next;
    logic                               full;
    logic                               is_write;
    logic                               push;
    logic                               pop;
    logic                               rd_take;
    logic                               rd_pending;
    logic                               ack_q;

    assign full     = (count == mem_route_pkg::SB_COUNT_MAX);
    assign is_write = (cpu_req.op == mem_route_pkg::OP_WRITE);

    // Reads wait for an empty queue, writes for a free slot
    assign ready   = is_write ? ((state != READ_WAIT) && !full) : (state == IDLE);
    assign push    = take && is_write;
    assign rd_take = take && !is_write;
    assign pop     = (count != '0) && issue_ready;

    always_comb begin
        entry = '{valid: 1'b1,
                  op:    cpu_req.op,
                  wstrb: cpu_req.wstrb,
                  addr:  cpu_req.addr,
                  wdata: cpu_req.wdata};
    end

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (rd_take) begin
                    state_next = READ_WAIT;
                end else if (push) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                if (count_next == '0) begin
                    state_next = IDLE;
                end
            end
            READ_WAIT: begin
                if (mem_rsp.valid) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= IDLE;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            rd_pending <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            ack_q <= push;
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (rd_take) begin
                rd_pending <= 1'b1;
            end else if (rd_pending && issue_ready) begin
                rd_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            queue[tail] <= entry;
        end
        if (rd_take) begin
            rd_q <= entry;
        end
    end

    // Pending read only exists with an empty queue
    always_comb begin
        if (rd_pending) begin
            issue_req = rd_q;
        end else begin
            issue_req       = queue[head];
            issue_req.valid = (count != '0);
        end
    end

    // Posted write ack, or the read data from downstream
    always_comb begin
        done.valid = ack_q || mem_rsp.valid;
        done.rdata = ack_q ? '0 : mem_rsp.rdata;
    end

endmodule

// File: design/credit_issue.sv
module credit_issue (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  mem_route_pkg::mem_req_t in_req,
    input  logic                    credit,
    output logic                    in_ready,
    output mem_route_pkg::mem_req_t port_req
);

    logic [mem_route_pkg::CREDIT_W-1:0] credits;
    logic                               take;
    logic                               beat_valid;
    mem_route_pkg::mem_req_t            beat_q;

    // Credit is spent when the beat is taken, one cycle before it shows up
    assign in_ready = (credits != '0);
    assign take     = in_req.valid && in_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            credits    <= mem_route_pkg::CREDIT_INIT;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= take;
            case ({take, credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output beat
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (take) begin
            beat_q      <= in_req;
            beat_q.addr <= in_req.addr & mem_route_pkg::SEG_MASK;
        end
    end

    always_comb begin
        port_req       = beat_q;
        port_req.valid = beat_valid;
    end

endmodule

// File: design/mem_router_top.sv
module mem_router_top (
    input  logic                    aclk,
    input  logic                    aresetn,

    // CPU side
    input  mem_route_pkg::cpu_req_t cpu_req,
    output logic                    addr_ok,
    output mem_route_pkg::mem_rsp_t cpu_rsp,

    // Cached port
    output mem_route_pkg::mem_req_t cached_req,
    input  mem_route_pkg::mem_rsp_t cached_rsp,
    input  logic                    cached_credit,

    // Uncached port
    output mem_route_pkg::mem_req_t uncached_req,
    input  mem_route_pkg::mem_rsp_t uncached_rsp,
    input  logic                    uncached_credit
);

    logic                    cached_take;
    logic                    cached_ready;
    logic                    uncached_take;
    logic                    uncached_ready;
    logic                    sb_issue_ready;
    mem_route_pkg::mem_req_t cached_in;
    mem_route_pkg::mem_req_t sb_issue;
    mem_route_pkg::mem_rsp_t uncached_done;

    ////////////////////////////////////////////////////////////////////////////
    // Order tracker
    ////////////////////////////////////////////////////////////////////////////

    route_tracker route_tracker_inst (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .cpu_req        (cpu_req),
        .cached_ready   (cached_ready),
        .uncached_ready (uncached_ready),
        .cached_done    (cached_rsp),
        .uncached_done  (uncached_done),
        .addr_ok        (addr_ok),
        .cached_take    (cached_take),
        .uncached_take  (uncached_take),
        .cpu_rsp        (cpu_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Cached path
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        cached_in = '{valid: cached_take,
                      op:    cpu_req.op,
                      wstrb: cpu_req.wstrb,
                      addr:  cpu_req.addr,
                      wdata: cpu_req.wdata};
    end

    credit_issue cached_issue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_req   (cached_in),
        .credit   (cached_credit),
        .in_ready (cached_ready),
        .port_req (cached_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Uncached path
    ////////////////////////////////////////////////////////////////////////////

    store_buffer store_buffer_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .take        (uncached_take),
        .cpu_req     (cpu_req),
        .issue_ready (sb_issue_ready),
        .mem_rsp     (uncached_rsp),
        .ready       (uncached_ready),
        .done        (uncached_done),
        .issue_req   (sb_issue)
    );

    credit_issue uncached_issue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_req   (sb_issue),
        .credit   (uncached_credit),
        .in_ready (sb_issue_ready),
        .port_req (uncached_req)
    );

endmodule

// File: verification/mem_model.sv
module mem_model (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    answer_writes,
    input  mem_route_pkg::mem_req_t req,
    output mem_route_pkg::mem_rsp_t rsp,
    output logic                    credit
);

    timeunit 1ns;
    timeprecision 1ps;

    // Word storage keyed by word address
    logic [31:0]             words [logic [29:0]];
    int unsigned             now;
    int unsigned             credit_due [$];
    int unsigned             rsp_due [$];
    logic [31:0]             rsp_words [$];
    mem_route_pkg::mem_rsp_t rsp_q = '0;
    logic                    credit_q = 1'b0;

    assign rsp    = rsp_q;
    assign credit = credit_q;

    // Unwritten words return a pattern of their own address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (words.exists(addr[31:2])) begin
            return words[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a3c_96e1;
    endfunction

    task automatic write_word(input mem_route_pkg::mem_req_t beat);
        logic [31:0] word;
        word = read_word(beat.addr);
        for (int b = 0; b < mem_route_pkg::STRB_W; b++) begin
            if (beat.wstrb[b]) begin
                word[8*b +: 8] = beat.wdata[8*b +: 8];
            end
        end
        words[beat.addr[31:2]] = word;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Beat intake, credits and responses
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge aclk) begin
        if (!aresetn) begin
            now      = 0;
            rsp_q    = '0;
            credit_q = 1'b0;
            credit_due.delete();
            rsp_due.delete();
            rsp_words.delete();
        end else begin
            now++;
            rsp_q    = '0;
            credit_q = 1'b0;
            if (req.valid) begin
                credit_due.push_back(now + 1 + $urandom % 6);
                if (req.op == mem_route_pkg::OP_WRITE) begin
                    write_word(req);
                end
                // Uncached port stays silent on writes
                if (req.op == mem_route_pkg::OP_READ || answer_writes) begin
                    rsp_due.push_back(now + 1 + $urandom % 5);
                    rsp_words.push_back((req.op == mem_route_pkg::OP_READ) ?
                                        read_word(req.addr) : 32'h0);
                end
            end
            if (credit_due.size() != 0 && credit_due[0] <= now) begin
                void'(credit_due.pop_front());
                credit_q = 1'b1;
            end
            if (rsp_due.size() != 0 && rsp_due[0] <= now) begin
                void'(rsp_due.pop_front());
                rsp_q.valid = 1'b1;
                rsp_q.rdata = rsp_words.pop_front();
            end
        end
    end

endmodule

// File: verification/tb_mem_router.sv
module tb_mem_router;

    timeunit 1ns;
    timeprecision 1ps;

    logic                    aclk = 1'b0;
    logic                    aresetn;
    mem_route_pkg::cpu_req_t cpu_req;
    logic                    addr_ok;
    mem_route_pkg::mem_rsp_t cpu_rsp;
    mem_route_pkg::mem_req_t cached_req;
    mem_route_pkg::mem_rsp_t cached_rsp;
    logic                    cached_credit;
    mem_route_pkg::mem_req_t uncached_req;
    mem_route_pkg::mem_rsp_t uncached_rsp;
    logic                    uncached_credit;

    // Expected CPU responses and downstream addresses with the oldest at the front
    string       rsp_name [$];
    logic [31:0] rsp_data [$];
    string       cached_name [$];
    logic [31:0] cached_addr [$];
    string       uncached_name [$];
    logic [31:0] uncached_addr [$];
    int          cached_open = 0;
    int          uncached_open = 0;

    always #4 aclk = ~aclk;

    mem_router_top mem_router_top_inst (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .cpu_req         (cpu_req),
        .addr_ok         (addr_ok),
        .cpu_rsp         (cpu_rsp),
        .cached_req      (cached_req),
        .cached_rsp      (cached_rsp),
        .cached_credit   (cached_credit),
        .uncached_req    (uncached_req),
        .uncached_rsp    (uncached_rsp),
        .uncached_credit (uncached_credit)
    );

    mem_model cached_mem (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .answer_writes (1'b1),
        .req           (cached_req),
        .rsp           (cached_rsp),
        .credit        (cached_credit)
    );

    mem_model uncached_mem (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .answer_writes (1'b0),
        .req           (uncached_req),
        .rsp           (uncached_rsp),
        .credit        (uncached_credit)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // Router drops the top three address bits
    function automatic logic [31:0] mapped(input logic [31:0] addr);
        return {3'b000, addr[28:0]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Response, address and credit monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (aresetn) begin
            if (cpu_rsp.valid) begin
                if (rsp_data.size() == 0) begin
                    abort_run("CPU response arrived with no request outstanding");
                end else begin
                    check_value(rsp_name.pop_front(), rsp_data.pop_front(), cpu_rsp.rdata);
                end
            end
            if (cached_req.valid) begin
                if (cached_addr.size() == 0) begin
                    abort_run("unexpected beat on the cached port");
                end else begin
                    check_value(cached_name.pop_front(), cached_addr.pop_front(),
                                cached_req.addr);
                end
                cached_open++;
            end
            if (uncached_req.valid) begin
                if (uncached_addr.size() == 0) begin
                    abort_run("unexpected beat on the uncached port");
                end else begin
                    check_value(uncached_name.pop_front(), uncached_addr.pop_front(),
                                uncached_req.addr);
                end
                uncached_open++;
            end
            if (cached_credit) begin
                cached_open--;
            end
            if (uncached_credit) begin
                uncached_open--;
            end
            if (cached_open > mem_route_pkg::MEM_CREDITS || cached_open < 0) begin
                abort_run("cached port beats and returned credits are out of balance");
            end
            if (uncached_open > mem_route_pkg::MEM_CREDITS || uncached_open < 0) begin
                abort_run("uncached port beats and returned credits are out of balance");
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int           fd;
        int           n;
        int           sent;
        int           wait_cycles;
        string        line;
        string        name;
        logic [127:0] name_bits;
        logic         op;
        logic         cacheable;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [31:0]  expected;
        logic         accepted;

        void'($urandom(32'h5db7a26c));
        cpu_req   = '0;
        aresetn   = 1'b0;
        sent      = 0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // After reset addr_ok is high and nothing is valid
        repeat (4) begin
            @(posedge aclk);
            check_value("reset_idle", 32'h8, {28'd0, addr_ok, cpu_rsp.valid,
                                              cached_req.valid, uncached_req.valid});
        end
        @(negedge aclk);

        fd = $fopen("verification/router_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h %h %h %h", name_bits, op, cacheable, addr, wdata,
                        expected);
            if (n == 6 && line.getc(0) != 8'h23) begin
                name              = string'(name_bits);
                cpu_req.valid     = 1'b1;
                cpu_req.op        = op ? mem_route_pkg::OP_WRITE : mem_route_pkg::OP_READ;
                cpu_req.cacheable = cacheable;
                cpu_req.size      = 2'b10;
                cpu_req.wstrb     = 4'hf;
                cpu_req.addr      = addr;
                cpu_req.wdata     = wdata;
                accepted    = 1'b0;
                wait_cycles = 0;
                while (!accepted) begin
                    @(posedge aclk);
                    accepted = addr_ok;
                    wait_cycles++;
                    if (!accepted && wait_cycles >= 200) begin
                        abort_run("timeout waiting for addr_ok on a held request");
                    end
                end
                rsp_name.push_back(name);
                rsp_data.push_back(op ? 32'h0 : expected);
                if (cacheable) begin
                    cached_name.push_back(name);
                    cached_addr.push_back(mapped(addr));
                end else begin
                    uncached_name.push_back(name);
                    uncached_addr.push_back(mapped(addr));
                end
                sent++;
                @(negedge aclk);
                cpu_req.valid = 1'b0;
                // Occasional idle cycle between requests
                if ($urandom % 4 == 0) begin
                    @(negedge aclk);
                end
            end
        end
        $fclose(fd);

        wait_cycles = 0;
        while (rsp_data.size() != 0 || cached_open != 0 || uncached_open != 0) begin
            @(negedge aclk);
            wait_cycles++;
            if (wait_cycles >= 500) begin
                abort_run("timeout waiting for outstanding responses and credits");
            end
        end

        if (sent != 0 && cached_addr.size() == 0 && uncached_addr.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("no requests sent or downstream beats missing");
            $display("TB FAILED");
            $fatal(1, "incomplete run");
        end
    end

endmodule

// File: verification/router_stimulus.txt
# name op cacheable addr wdata rdata
# op 1 is a write, numeric columns in hex, writes expect zero data
cached_wr_rd  1 1 a0000010 11112222 00000000
cached_wr_rd  1 1 a0000014 33334444 00000000
cached_wr_rd  0 1 a0000010 00000000 11112222
cached_wr_rd  0 1 20000014 00000000 33334444
cached_wr_rd  0 1 10000040 00000000 4a3c96a1
posted_wr     1 0 e0000100 aaaa0001 00000000
posted_wr     1 0 e0000100 aaaa0002 00000000
posted_wr     1 0 e0000104 bbbb0001 00000000
posted_wr     1 0 e0000100 aaaa0003 00000000
posted_wr     1 0 e0000100 aaaa0004 00000000
posted_wr     1 0 e0000100 aaaa0005 00000000
posted_wr     0 0 e0000100 00000000 aaaa0005
posted_wr     0 0 00000104 00000000 bbbb0001
posted_wr     0 0 e0000200 00000000 5a3c94e1
mixed_order   1 1 80000020 c0de0001 00000000
mixed_order   1 0 80000020 d00d0001 00000000
mixed_order   0 1 80000020 00000000 c0de0001
mixed_order   0 0 80000020 00000000 d00d0001
mixed_order   1 0 40000030 e0e0e0e0 00000000
mixed_order   0 1 a0000010 00000000 11112222
mixed_order   0 0 40000030 00000000 e0e0e0e0
credit_burst  1 1 c0000300 50000300 00000000
credit_burst  1 1 c0000304 50000304 00000000
credit_burst  1 1 c0000308 50000308 00000000
credit_burst  1 1 c000030c 5000030c 00000000
credit_burst  1 1 c0000310 50000310 00000000
credit_burst  1 1 c0000314 50000314 00000000
credit_burst  0 1 00000300 00000000 50000300
credit_burst  0 1 00000304 00000000 50000304
credit_burst  0 1 00000308 00000000 50000308
credit_burst  0 1 0000030c 00000000 5000030c
credit_burst  0 1 00000310 00000000 50000310
credit_burst  0 1 00000314 00000000 50000314

// File: tb.f
design/mem_route_pkg.sv
design/route_tracker.sv
design/store_buffer.sv
design/credit_issue.sv
design/mem_router_top.sv
verification/mem_model.sv
verification/tb_mem_router.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the router testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_mem_router -f tb.f -o tb_mem_router &&
./obj_dir/tb_mem_router ||
{ echo "simulation failed"; exit 1; }
